/* verilog/walkerPkg.sv */
package walkerPkg;

  ////////////////////////////////////////////////////////////////////////////
  // Sv32 field widths
  ////////////////////////////////////////////////////////////////////////////

  // One virtual page number segment
  localparam int VPN_BITS = 10;
  // Physical page number held in satp and in every entry
  localparam int PPN_BITS = 22;
  // Physical address is 34 bits in Sv32
  localparam int PA_BITS = 34;
  localparam int PTE_BITS = 32;
  localparam int OFFSET_BITS = 12;
  // Virtual address, two VPN segments plus the offset
  localparam int XLEN = 2 * VPN_BITS + OFFSET_BITS;

  // Bit positions inside a page table entry
  localparam int PTE_V = 0;
  localparam int PTE_R = 1;
  localparam int PTE_W = 2;
  localparam int PTE_X = 3;
  localparam int PTE_A = 6;
  localparam int PTE_D = 7;
  // Page number starts above the RSW field
  localparam int PPN_LSB = 10;

  ////////////////////////////////////////////////////////////////////////////
  // Walker types
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    idle,
    start,
    level1Wait,
    level1,
    level0Wait,
    level0,
    leaf,
    fault
  } walkerState;

  // Level 1 leaf maps 4 MiB, level 0 leaf maps 4 KiB
  typedef enum logic {kiloPage, megaPage} pageSize;

  // Top bit of satp
  typedef enum logic {bare, sv32} satpMode;

endpackage

/* verilog/walkRequest.sv */
`timescale 1ns/10ps

module walkRequest import walkerPkg::*; (
  input  logic            clk,
  input  logic            reset,
  input  logic [XLEN-1:0] pcF,
  input  logic [XLEN-1:0] memAdrM,
  input  logic            itlbMissF,
  input  logic            dtlbMissM,
  input  logic            memStoreM,
  input  logic            startWalk,
  input  logic            pteWrite,
  input  logic            walkFault,
  output logic [XLEN-1:0] virtAdr,
  output logic            walkPending,
  output logic            isStore,
  output logic            itlbWrite,
  output logic            dtlbWrite,
  output logic            instrPageFault,
  output logic            loadPageFault,
  output logic            storePageFault
);

  // Walk belongs to the data side
  logic dataSide;
  // Single end strobe of the walk
  logic endWalk;

  assign endWalk = pteWrite | walkFault;

  ////////////////////////////////////////////////////////////////////////////
  // Request capture
  ////////////////////////////////////////////////////////////////////////////

  // Data miss wins when both sides miss together
  always_ff @(posedge clk) begin
    if (startWalk) begin
      virtAdr <= dtlbMissM ? memAdrM : pcF;
    end
  end

  // Side and store flag are frozen for the whole walk
  always_ff @(posedge clk) begin
    if (reset) begin
      walkPending <= 1'b0;
      dataSide    <= 1'b0;
      isStore     <= 1'b0;
    end else if (startWalk) begin
      walkPending <= 1'b1;
      dataSide    <= dtlbMissM;
      // Instruction fetches are never stores
      isStore     <= dtlbMissM & memStoreM;
    end else if (endWalk) begin
      walkPending <= 1'b0;
      dataSide    <= 1'b0;
      isStore     <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Strobe steering
  ////////////////////////////////////////////////////////////////////////////

  // Entry goes to the TLB that missed
  assign itlbWrite = pteWrite & ~dataSide;
  assign dtlbWrite = pteWrite & dataSide;

  // Fault kind follows the side and the access type
  assign instrPageFault = walkFault & ~dataSide;
  assign loadPageFault  = walkFault & dataSide & ~isStore;
  assign storePageFault = walkFault & dataSide & isStore;

endmodule

/* verilog/pteCheck.sv */
`timescale 1ns/10ps

module pteCheck import walkerPkg::*; (
  input  logic                clk,
  input  logic                reset,
  input  logic                captureEn,
  input  logic [PTE_BITS-1:0] readPte,
  input  logic                isStore,
  output logic [PTE_BITS-1:0] pte,
  output logic [PPN_BITS-1:0] entryPpn,
  output logic                validPte,
  output logic                leafPte,
  output logic                accessAlert,
  output logic                megaMisaligned
);

  // Permission and status bits of the held entry
  logic valid;
  logic readable;
  logic writable;
  logic executable;
  logic accessed;
  logic dirty;

  ////////////////////////////////////////////////////////////////////////////
  // Entry register
  ////////////////////////////////////////////////////////////////////////////

  // Loaded in the first unstalled wait cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      pte <= '0;
    end else if (captureEn) begin
      pte <= readPte;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Entry decode
  ////////////////////////////////////////////////////////////////////////////

  assign valid      = pte[PTE_V];
  assign readable   = pte[PTE_R];
  assign writable   = pte[PTE_W];
  assign executable = pte[PTE_X];
  assign accessed   = pte[PTE_A];
  assign dirty      = pte[PTE_D];

  // Next level pointer or leaf frame number
  assign entryPpn = pte[PPN_LSB +: PPN_BITS];

  // W without R is a reserved encoding
  assign validPte = valid & ~(writable & ~readable);

  // Any permission bit marks a leaf, none is a pointer
  assign leafPte = readable | writable | executable;

  // Hardware does not set A or D, so software must have
  assign accessAlert = ~accessed | (isStore & ~dirty);

  // Megapage needs PPN[0] all zero
  assign megaMisaligned = |entryPpn[VPN_BITS-1:0];

endmodule

/* verilog/walkController.sv */
`timescale 1ns/10ps

module walkController import walkerPkg::*; (
  input  logic                clk,
  input  logic                reset,
  input  logic [XLEN-1:0]     satp,
  input  logic                walkPending,
  input  logic                itlbMissF,
  input  logic                dtlbMissM,
  input  logic [XLEN-1:0]     virtAdr,
  input  logic [PPN_BITS-1:0] entryPpn,
  input  logic                validPte,
  input  logic                leafPte,
  input  logic                accessAlert,
  input  logic                megaMisaligned,
  input  logic                hptwStall,
  output logic                startWalk,
  output logic                captureEn,
  output logic                hptwRead,
  output logic [PA_BITS-1:0]  physAdr,
  output pageSize             pageType,
  output logic                pteWrite,
  output logic                walkFault
);

  walkerState state;
  walkerState nextState;

  satpMode             mode;
  logic [PPN_BITS-1:0] rootPpn;
  logic [VPN_BITS-1:0] vpn1;
  logic [VPN_BITS-1:0] vpn0;
  logic [PA_BITS-1:0]  level1Adr;
  logic [PA_BITS-1:0]  level0Adr;

  // Outcome of an evaluate cycle
  logic megaLeafOk;
  logic kiloLeafOk;
  logic descend;

  ////////////////////////////////////////////////////////////////////////////
  // Address forming
  ////////////////////////////////////////////////////////////////////////////

  assign mode    = satpMode'(satp[XLEN-1]);
  assign rootPpn = satp[PPN_BITS-1:0];

  // VPN1 sits above VPN0, both above the page offset
  assign vpn1 = virtAdr[OFFSET_BITS+VPN_BITS +: VPN_BITS];
  assign vpn0 = virtAdr[OFFSET_BITS +: VPN_BITS];

  // Entries are 4 bytes, so index times 4
  assign level1Adr = {rootPpn, vpn1, 2'b00};
  assign level0Adr = {entryPpn, vpn0, 2'b00};

  // Level 1 leaf must also be megapage aligned
  assign megaLeafOk = validPte & leafPte & ~megaMisaligned & ~accessAlert;
  assign descend    = validPte & ~leafPte;
  assign kiloLeafOk = validPte & leafPte & ~accessAlert;

  // Bare mode never walks, the miss just waits
  assign startWalk = (state == idle) & (itlbMissF | dtlbMissM) & (mode == sv32);

  ////////////////////////////////////////////////////////////////////////////
  // Walk FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= idle;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    captureEn = 1'b0;
    hptwRead  = 1'b0;
    physAdr   = '0;
    pageType  = kiloPage;
    pteWrite  = 1'b0;
    walkFault = 1'b0;
    case (state)
      idle: begin
        // Request block captures the miss this cycle
        if (startWalk) begin
          nextState = start;
        end
      end
      start: begin
        // Capture happened last cycle, address is now settled
        if (walkPending) begin
          hptwRead  = 1'b1;
          physAdr   = level1Adr;
          nextState = level1Wait;
        end else begin
          nextState = idle;
        end
      end
      level1Wait: begin
        // Hold the address until memory stops stalling
        physAdr = level1Adr;
        if (!hptwStall) begin
          captureEn = 1'b1;
          nextState = level1;
        end
      end
      level1: begin
        if (megaLeafOk) begin
          pteWrite  = 1'b1;
          pageType  = megaPage;
          nextState = leaf;
        end else if (descend) begin
          // Pointer to the level 0 table
          hptwRead  = 1'b1;
          physAdr   = level0Adr;
          nextState = level0Wait;
        end else begin
          nextState = fault;
        end
      end
      level0Wait: begin
        physAdr = level0Adr;
        if (!hptwStall) begin
          captureEn = 1'b1;
          nextState = level0;
        end
      end
      level0: begin
        // A pointer at the last level is a fault too
        if (kiloLeafOk) begin
          pteWrite  = 1'b1;
          pageType  = kiloPage;
          nextState = leaf;
        end else begin
          nextState = fault;
        end
      end
      leaf: begin
        // Gives the TLB a cycle to drop its miss
        nextState = idle;
      end
      fault: begin
        walkFault = 1'b1;
        nextState = idle;
      end
      default: begin
        nextState = idle;
      end
    endcase
  end

endmodule

/* verilog/pageTableWalker.sv */
`timescale 1ns/10ps

module pageTableWalker import walkerPkg::*; (
  input  logic                clk,
  input  logic                reset,
  input  logic [XLEN-1:0]     satp,
  input  logic [XLEN-1:0]     pcF,
  input  logic [XLEN-1:0]     memAdrM,
  input  logic                itlbMissF,
  input  logic                dtlbMissM,
  input  logic                memStoreM,
  input  logic [PTE_BITS-1:0] readPte,
  input  logic                hptwStall,
  output logic [PTE_BITS-1:0] pageTableEntry,
  output pageSize             pageType,
  output logic                itlbWrite,
  output logic                dtlbWrite,
  output logic [PA_BITS-1:0]  physAdr,
  output logic                hptwRead,
  output logic                walkActive,
  output logic                instrPageFault,
  output logic                loadPageFault,
  output logic                storePageFault
);

  // Request side to controller
  logic [XLEN-1:0]     virtAdr;
  logic                isStore;
  logic                startWalk;

  // Controller to request side
  logic                pteWrite;
  logic                walkFault;

  // Controller and entry checker
  logic                captureEn;
  logic [PPN_BITS-1:0] entryPpn;
  logic                validPte;
  logic                leafPte;
  logic                accessAlert;
  logic                megaMisaligned;

  ////////////////////////////////////////////////////////////////////////////
  // Miss capture and strobe steering
  ////////////////////////////////////////////////////////////////////////////

  // Pending level doubles as the walk active output
  walkRequest walkRequest_i (
    .clk            (clk),
    .reset          (reset),
    .pcF            (pcF),
    .memAdrM        (memAdrM),
    .itlbMissF      (itlbMissF),
    .dtlbMissM      (dtlbMissM),
    .memStoreM      (memStoreM),
    .startWalk      (startWalk),
    .pteWrite       (pteWrite),
    .walkFault      (walkFault),
    .virtAdr        (virtAdr),
    .walkPending    (walkActive),
    .isStore        (isStore),
    .itlbWrite      (itlbWrite),
    .dtlbWrite      (dtlbWrite),
    .instrPageFault (instrPageFault),
    .loadPageFault  (loadPageFault),
    .storePageFault (storePageFault)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Level sequencing
  ////////////////////////////////////////////////////////////////////////////

  walkController walkController_i (
    .clk            (clk),
    .reset          (reset),
    .satp           (satp),
    .walkPending    (walkActive),
    .itlbMissF      (itlbMissF),
    .dtlbMissM      (dtlbMissM),
    .virtAdr        (virtAdr),
    .entryPpn       (entryPpn),
    .validPte       (validPte),
    .leafPte        (leafPte),
    .accessAlert    (accessAlert),
    .megaMisaligned (megaMisaligned),
    .hptwStall      (hptwStall),
    .startWalk      (startWalk),
    .captureEn      (captureEn),
    .hptwRead       (hptwRead),
    .physAdr        (physAdr),
    .pageType       (pageType),
    .pteWrite       (pteWrite),
    .walkFault      (walkFault)
  );

  // Held entry is what the TLB writes
  pteCheck pteCheck_i (
    .clk            (clk),
    .reset          (reset),
    .captureEn      (captureEn),
    .readPte        (readPte),
    .isStore        (isStore),
    .pte            (pageTableEntry),
    .entryPpn       (entryPpn),
    .validPte       (validPte),
    .leafPte        (leafPte),
    .accessAlert    (accessAlert),
    .megaMisaligned (megaMisaligned)
  );

endmodule

/* verif/pageTableWalker_checker.sv */
`timescale 1ns/10ps

module pageTableWalker_checker (
  input logic clk,
  input logic reset,
  input logic hptwRead,
  input logic walkActive,
  input logic itlbWrite,
  input logic dtlbWrite,
  input logic instrPageFault,
  input logic loadPageFault,
  input logic storePageFault
);

  // All end strobes of a walk
  logic [4:0] endStrobes;

  assign endStrobes = {itlbWrite, dtlbWrite, instrPageFault, loadPageFault, storePageFault};

  ////////////////////////////////////////////////////////////////////////////
  // Port protocol
  ////////////////////////////////////////////////////////////////////////////

  // Never more than one end strobe in a cycle
  oneEndStrobe: assert property (@(posedge clk) disable iff (reset) $onehot0(endStrobes))
    else $error("more than one end strobe in one cycle");

  // Memory is only read inside a walk
  readInWalk: assert property (@(posedge clk) disable iff (reset) hptwRead |-> walkActive)
    else $error("hptwRead while no walk is active");

  // First reset edge only sets the state, check from the second on
  quietInReset: assert property (@(posedge clk)
      (reset && $past(reset)) |-> (endStrobes == 5'b0 && !hptwRead))
    else $error("strobe or memory read during reset");

endmodule

/* verif/walkerTb.sv */
`timescale 1ns/10ps

module walkerTb import walkerPkg::*; ();

  // Kind of end strobe seen on the TLB side
  typedef enum logic [2:0] {
    endNone,
    endItlbWrite,
    endDtlbWrite,
    endInstrFault,
    endLoadFault,
    endStoreFault
  } endKind;

  // Entry flag bits, low byte of a page table entry
  localparam logic [7:0] flagV = 8'h01;
  localparam logic [7:0] flagR = 8'h02;
  localparam logic [7:0] flagW = 8'h04;
  localparam logic [7:0] flagX = 8'h08;
  localparam logic [7:0] flagA = 8'h40;
  localparam logic [7:0] flagD = 8'h80;
  localparam logic [PPN_BITS-1:0] rootPpn = 22'h00080;
  // Shows up on readPte while memory stalls
  localparam logic [PTE_BITS-1:0] junkPte = 32'hdeadbeef;
  // About 40 walks of up to 20 cycles each, plus reset and the bare mode wait
  localparam int cycleLimit = 3000;

  logic clk;
  logic reset;
  logic [XLEN-1:0] satp;
  logic [XLEN-1:0] pcF;
  logic [XLEN-1:0] memAdrM;
  logic itlbMissF;
  logic dtlbMissM;
  logic memStoreM;
  logic [PTE_BITS-1:0] readPte = '0;
  logic hptwStall = 1'b0;
  logic [PTE_BITS-1:0] pageTableEntry;
  pageSize pageType;
  logic itlbWrite;
  logic dtlbWrite;
  logic [PA_BITS-1:0] physAdr;
  logic hptwRead;
  logic walkActive;
  logic instrPageFault;
  logic loadPageFault;
  logic storePageFault;

  // Page table memory and its read bookkeeping
  logic [PTE_BITS-1:0] pageMem [logic [PA_BITS-1:0]];
  logic [PA_BITS-1:0] expAdrQ [$];
  logic [PA_BITS-1:0] expAdr = '0;
  logic [PA_BITS-1:0] lastAdr = '0;
  int stallLeft = 0;
  int waitNegs = 0;
  int stallCycles = 0;
  int cycleCount = 0;
  logic randomStall = 1'b0;
  logic [31:0] lfsr = 32'h1fc;
  string curTest = "reset";

  pageTableWalker pageTableWalker_i (.*);

  bind pageTableWalker pageTableWalker_checker pageTableWalker_checker_i (
    .clk            (clk),
    .reset          (reset),
    .hptwRead       (hptwRead),
    .walkActive     (walkActive),
    .itlbWrite      (itlbWrite),
    .dtlbWrite      (dtlbWrite),
    .instrPageFault (instrPageFault),
    .loadPageFault  (loadPageFault),
    .storePageFault (storePageFault)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Error reporting and helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic abortRun();
    $display("Regression failed");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic reportMismatch(input string testName, input logic [63:0] exp,
                                input logic [63:0] act);
    $display("Fail %s expected %0h actual %0h", testName, exp, act);
    abortRun();
  endtask

  task automatic reportError(input string msg);
    $display("Error: %s", msg);
    abortRun();
  endtask

  // Taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // Two bits, one LFSR step each, give 0 to 3 stall cycles
  task automatic drawStall(output int len);
    len = 0;
    repeat (2) begin
      len = (len << 1) | {31'b0, lfsr[0]};
      lfsr = lfsrNext(lfsr);
    end
  endtask

  function automatic logic [XLEN-1:0] makeSatp(input satpMode m);
    return {m, 9'h000, rootPpn};
  endfunction

  function automatic logic [XLEN-1:0] makeVa(input logic [9:0] vpn1, input logic [9:0] vpn0,
                                             input logic [11:0] offset);
    return {vpn1, vpn0, offset};
  endfunction

  function automatic logic [PTE_BITS-1:0] makePte(input logic [21:0] ppn,
                                                  input logic [7:0] flags);
    return {ppn, 2'b00, flags};
  endfunction

  // Table base times 4 KiB plus index times 4
  function automatic logic [PA_BITS-1:0] entryAdr(input logic [21:0] tablePpn,
                                                  input logic [9:0] index);
    return {tablePpn, index, 2'b00};
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Memory model and timeout
  ////////////////////////////////////////////////////////////////////////////

  // Read pulse seen on one falling edge, wait state on the following ones
  always @(negedge clk) begin
    if (hptwRead) begin
      assert (expAdrQ.size() != 0)
        else reportError($sformatf("%s: unexpected page table read at %h", curTest, physAdr));
      expAdr = expAdrQ.pop_front();
      assert (physAdr == expAdr) else reportMismatch(curTest, 64'(expAdr), 64'(physAdr));
      lastAdr = physAdr;
      if (randomStall) begin
        drawStall(stallLeft);
      end else begin
        stallLeft = 0;
      end
      waitNegs = stallLeft + 1;
      hptwStall = 1'b1;
      readPte = junkPte;
    end else if (waitNegs != 0) begin
      // Address must hold through the whole wait
      assert (physAdr == lastAdr) else reportMismatch(curTest, 64'(lastAdr), 64'(physAdr));
      if (stallLeft != 0) begin
        hptwStall = 1'b1;
        readPte = junkPte;
        stallLeft = stallLeft - 1;
        stallCycles = stallCycles + 1;
      end else begin
        hptwStall = 1'b0;
        readPte = pageMem.exists(lastAdr) ? pageMem[lastAdr] : '0;
      end
      waitNegs = waitNegs - 1;
    end
  end

  always @(posedge clk) begin
    cycleCount = cycleCount + 1;
    if (cycleCount >= cycleLimit) begin
      reportError($sformatf("timeout after %0d cycles in %s", cycleCount, curTest));
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Walk driving
  ////////////////////////////////////////////////////////////////////////////

  task automatic prepareTable(input string testName);
    curTest = testName;
    pageMem.delete();
  endtask

  task automatic startMiss(input logic dataSide, input logic store, input logic [XLEN-1:0] va);
    if (dataSide) begin
      memAdrM = va;
      memStoreM = store;
      dtlbMissM = 1'b1;
    end else begin
      pcF = va;
      itlbMissF = 1'b1;
    end
  endtask

  task automatic dropMiss(input logic dataSide);
    if (dataSide) begin
      dtlbMissM = 1'b0;
      memStoreM = 1'b0;
    end else begin
      itlbMissF = 1'b0;
    end
  endtask

  // Returns on the falling edge inside the strobe cycle
  task automatic awaitEnd(input endKind expKind, input logic [PTE_BITS-1:0] expPte,
                          input pageSize expType);
    endKind kind;
    kind = endNone;
    while (kind == endNone) begin
      @(negedge clk);
      if (itlbWrite) kind = endItlbWrite;
      else if (dtlbWrite) kind = endDtlbWrite;
      else if (instrPageFault) kind = endInstrFault;
      else if (loadPageFault) kind = endLoadFault;
      else if (storePageFault) kind = endStoreFault;
    end
    assert (kind == expKind) else reportMismatch(curTest, 64'(expKind), 64'(kind));
    // Walk stays active up to and including its end strobe
    assert (walkActive)
      else reportError($sformatf("%s: walkActive low at the end strobe", curTest));
    if (kind == endItlbWrite || kind == endDtlbWrite) begin
      assert (pageTableEntry == expPte)
        else reportMismatch(curTest, 64'(expPte), 64'(pageTableEntry));
      assert (pageType == expType) else reportMismatch(curTest, 64'(expType), 64'(pageType));
    end
  endtask

  task automatic checkReadsDone();
    assert (expAdrQ.size() == 0)
      else reportError($sformatf("%s: %0d page table reads never came", curTest,
                                 expAdrQ.size()));
  endtask

  task automatic runWalk(input logic dataSide, input logic store, input logic [XLEN-1:0] va,
                         input endKind expKind, input logic [PTE_BITS-1:0] expPte,
                         input pageSize expType);
    @(negedge clk);
    startMiss(dataSide, store, va);
    awaitEnd(expKind, expPte, expType);
    dropMiss(dataSide);
    checkReadsDone();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic dataKiloWalk(input string testName);
    logic [PTE_BITS-1:0] leafPte;
    leafPte = makePte(22'h1a2b3, flagV | flagR | flagA);
    prepareTable(testName);
    pageMem[entryAdr(rootPpn, 10'h005)] = makePte(22'h00200, flagV);
    pageMem[entryAdr(22'h00200, 10'h123)] = leafPte;
    expAdrQ.push_back(entryAdr(rootPpn, 10'h005));
    expAdrQ.push_back(entryAdr(22'h00200, 10'h123));
    runWalk(1'b1, 1'b0, makeVa(10'h005, 10'h123, 12'h9a4), endDtlbWrite, leafPte, kiloPage);
  endtask

  task automatic fetchMegaWalk(input string testName);
    logic [PTE_BITS-1:0] leafPte;
    // Low 10 bits of the page number are zero
    leafPte = makePte(22'h0ac00, flagV | flagR | flagX | flagA);
    prepareTable(testName);
    pageMem[entryAdr(rootPpn, 10'h2c1)] = leafPte;
    expAdrQ.push_back(entryAdr(rootPpn, 10'h2c1));
    runWalk(1'b0, 1'b0, makeVa(10'h2c1, 10'h07f, 12'h010), endItlbWrite, leafPte, megaPage);
  endtask

  task automatic dataBeforeFetch(input string testName);
    logic [PTE_BITS-1:0] dataPte;
    logic [PTE_BITS-1:0] fetchPte;
    dataPte = makePte(22'h0beef, flagV | flagR | flagW | flagA | flagD);
    fetchPte = makePte(22'h01400, flagV | flagX | flagA);
    prepareTable(testName);
    pageMem[entryAdr(rootPpn, 10'h011)] = makePte(22'h00300, flagV);
    pageMem[entryAdr(22'h00300, 10'h0aa)] = dataPte;
    pageMem[entryAdr(rootPpn, 10'h012)] = fetchPte;
    // Data reads come first, then the fetch walk
    expAdrQ.push_back(entryAdr(rootPpn, 10'h011));
    expAdrQ.push_back(entryAdr(22'h00300, 10'h0aa));
    expAdrQ.push_back(entryAdr(rootPpn, 10'h012));
    @(negedge clk);
    startMiss(1'b1, 1'b0, makeVa(10'h011, 10'h0aa, 12'h444));
    startMiss(1'b0, 1'b0, makeVa(10'h012, 10'h3ff, 12'h800));
    awaitEnd(endDtlbWrite, dataPte, kiloPage);
    dropMiss(1'b1);
    awaitEnd(endItlbWrite, fetchPte, megaPage);
    dropMiss(1'b0);
    checkReadsDone();
  endtask

  task automatic loadInvalidFault(input string testName);
    prepareTable(testName);
    // Level 0 slot left empty, so the entry reads as zero
    pageMem[entryAdr(rootPpn, 10'h021)] = makePte(22'h00400, flagV);
    expAdrQ.push_back(entryAdr(rootPpn, 10'h021));
    expAdrQ.push_back(entryAdr(22'h00400, 10'h155));
    runWalk(1'b1, 1'b0, makeVa(10'h021, 10'h155, 12'h000), endLoadFault, '0, kiloPage);
  endtask

  task automatic storeMisalignedFault(input string testName);
    prepareTable(testName);
    pageMem[entryAdr(rootPpn, 10'h031)] =
      makePte(22'h0ac05, flagV | flagR | flagW | flagA | flagD);
    expAdrQ.push_back(entryAdr(rootPpn, 10'h031));
    runWalk(1'b1, 1'b1, makeVa(10'h031, 10'h001, 12'h020), endStoreFault, '0, kiloPage);
  endtask

  task automatic storeCleanFault(input string testName);
    prepareTable(testName);
    pageMem[entryAdr(rootPpn, 10'h041)] = makePte(22'h00500, flagV);
    pageMem[entryAdr(22'h00500, 10'h2aa)] = makePte(22'h0cafe, flagV | flagR | flagW | flagA);
    expAdrQ.push_back(entryAdr(rootPpn, 10'h041));
    expAdrQ.push_back(entryAdr(22'h00500, 10'h2aa));
    runWalk(1'b1, 1'b1, makeVa(10'h041, 10'h2aa, 12'hffc), endStoreFault, '0, kiloPage);
  endtask

  task automatic fetchWriteOnlyFault(input string testName);
    prepareTable(testName);
    pageMem[entryAdr(rootPpn, 10'h051)] = makePte(22'h00600, flagV);
    // W without R is reserved
    pageMem[entryAdr(22'h00600, 10'h0f0)] = makePte(22'h0f00d, flagV | flagW | flagX | flagA);
    expAdrQ.push_back(entryAdr(rootPpn, 10'h051));
    expAdrQ.push_back(entryAdr(22'h00600, 10'h0f0));
    runWalk(1'b0, 1'b0, makeVa(10'h051, 10'h0f0, 12'h100), endInstrFault, '0, kiloPage);
  endtask

  // Same walks and same results with the memory stalling
  task automatic stalledRepeats();
    randomStall = 1'b1;
    stallCycles = 0;
    repeat (4) begin
      dataKiloWalk("stalled dataKiloWalk");
      fetchMegaWalk("stalled fetchMegaWalk");
      dataBeforeFetch("stalled dataBeforeFetch");
      loadInvalidFault("stalled loadInvalidFault");
      storeMisalignedFault("stalled storeMisalignedFault");
      storeCleanFault("stalled storeCleanFault");
      fetchWriteOnlyFault("stalled fetchWriteOnlyFault");
    end
    randomStall = 1'b0;
    assert (stallCycles > 0) else reportError("random stalls never held the memory port");
  endtask

  task automatic bareModeIdle(input string testName);
    prepareTable(testName);
    @(negedge clk);
    satp = makeSatp(bare);
    itlbMissF = 1'b1;
    dtlbMissM = 1'b1;
    repeat (20) begin
      @(negedge clk);
      assert (!(hptwRead | walkActive | itlbWrite | dtlbWrite | instrPageFault |
                loadPageFault | storePageFault))
        else reportError("walker reacted to a miss in bare mode");
    end
    dropMiss(1'b1);
    dropMiss(1'b0);
    satp = makeSatp(sv32);
  endtask

  initial begin
    reset = 1'b1;
    satp = makeSatp(sv32);
    pcF = '0;
    memAdrM = '0;
    // Misses held through reset must not start a walk
    itlbMissF = 1'b1;
    dtlbMissM = 1'b1;
    memStoreM = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    dropMiss(1'b1);
    dropMiss(1'b0);
    assert (!(hptwRead | walkActive | itlbWrite | dtlbWrite | instrPageFault |
              loadPageFault | storePageFault))
      else reportError("walker left reset with a walk under way");
    dataKiloWalk("dataKiloWalk");
    fetchMegaWalk("fetchMegaWalk");
    dataBeforeFetch("dataBeforeFetch");
    loadInvalidFault("loadInvalidFault");
    storeMisalignedFault("storeMisalignedFault");
    storeCleanFault("storeCleanFault");
    fetchWriteOnlyFault("fetchWriteOnlyFault");
    stalledRepeats();
    bareModeIdle("bareModeIdle");
    repeat (2) @(negedge clk);
    $display("Regression passed");
    $finish;
  end

endmodule

/* list.f */
verilog/walkerPkg.sv
verilog/walkRequest.sv
verilog/pteCheck.sv
verilog/walkController.sv
verilog/pageTableWalker.sv
verif/pageTableWalker_checker.sv
verif/walkerTb.sv

/* run.sh */
#!/bin/sh
# Build and run the page table walker testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f list.f \
  --top-module walkerTb \
  -o walkerSim

# Exit status of the simulation is the result
./obj_dir/walkerSim
